// File: dcache_subsystem.f
source/l1d_pkg.sv
source/amo_alu.sv
source/core_dcache_adapter.sv
source/dcache_req_arbiter.sv
source/dcache_data_array.sv
source/dcache_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_dcache_subsystem.sv

// File: source/amo_alu.sv
`timescale 1ns/1ps
`default_nettype none

module amo_alu
  import l1d_pkg::*;
(
  input  wire req_op_e op_i,
  input  wire size_t   size_i,
  input  wire be_t     be_i,
  input  wire data_t   old_i,
  input  wire data_t   operand_i,
  output data_t        new_o
);

  logic [31:0] old_w;
  logic [31:0] opd_w;
  logic        is_word;
  data_t       a;
  data_t       b;
  logic        lt_s;
  logic        lt_u;
  data_t       res;
  data_t       placed;

  always_comb begin
    // Upper lane when the upper byte enables are set
    old_w   = be_i[4] ? old_i[63:32] : old_i[31:0];
    opd_w   = be_i[4] ? operand_i[63:32] : operand_i[31:0];
    is_word = (size_i == SIZE_WORD) && (op_i != REQ_STORE);

    // Sign extension keeps both signed and unsigned word ordering
    a = is_word ? {{32{old_w[31]}}, old_w} : old_i;
    b = is_word ? {{32{opd_w[31]}}, opd_w} : operand_i;

    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;

    case (op_i)
      AMO_ADD:  res = a + b;
      AMO_AND:  res = a & b;
      AMO_OR:   res = a | b;
      AMO_XOR:  res = a ^ b;
      AMO_MAX:  res = lt_s ? b : a;
      AMO_MAXU: res = lt_u ? b : a;
      AMO_MIN:  res = lt_s ? a : b;
      AMO_MINU: res = lt_u ? a : b;
      // Swap and plain stores write the operand
      default:  res = b;
    endcase

    placed = is_word ? {2{res[31:0]}} : res;

    for (int i = 0; i < BE_WIDTH; i++) begin
      new_o[8*i +: 8] = be_i[i] ? placed[8*i +: 8] : old_i[8*i +: 8];
    end
  end

endmodule

`default_nettype wire

// File: source/core_dcache_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module core_dcache_adapter
  import l1d_pkg::*;
#(
  parameter bit is_load_port = 1'b1
) (
  input  wire logic      clk_i,
  input  wire logic      rst_i,

  // Core load or store port
  input  wire logic      core_req_i,
  input  wire addr_t     core_addr_i,
  input  wire data_t     core_wdata_i,
  input  wire be_t       core_be_i,
  input  wire size_t     core_size_i,
  input  wire tid_t      core_id_i,
  output logic           core_gnt_o,
  output logic           core_rvalid_o,
  output data_t          core_rdata_o,
  output tid_t           core_rid_o,

  // Core AMO port
  input  wire logic      amo_req_i,
  input  wire core_amo_e amo_op_i,
  input  wire addr_t     amo_addr_i,
  input  wire data_t     amo_operand_i,
  input  wire size_t     amo_size_i,
  output logic           amo_ack_o,
  output data_t          amo_result_o,

  // Cache request
  output logic           req_valid_o,
  input  wire logic      req_ready_i,
  output req_op_e        req_op_o,
  output addr_t          req_addr_o,
  output data_t          req_wdata_o,
  output be_t            req_be_o,
  output size_t          req_size_o,
  output tid_t           req_tid_o,
  output logic           req_need_rsp_o,

  // Cache response
  input  wire logic      rsp_valid_i,
  input  wire data_t     rsp_rdata_i,
  input  wire tid_t      rsp_tid_i
);

  assign core_gnt_o = req_ready_i;

  if (is_load_port) begin : load_port_gen
    assign req_valid_o    = core_req_i;
    assign req_op_o       = REQ_LOAD;
    assign req_addr_o     = core_addr_i;
    assign req_wdata_o    = '0;
    assign req_be_o       = core_be_i;
    assign req_size_o     = core_size_i;
    assign req_tid_o      = core_id_i;
    assign req_need_rsp_o = 1'b1;

    // Every response on this port belongs to a load
    assign core_rvalid_o = rsp_valid_i;
    assign core_rdata_o  = rsp_rdata_i;
    assign core_rid_o    = rsp_tid_i;

    assign amo_ack_o    = 1'b0;
    assign amo_result_o = '0;
  end else begin : store_amo_gen
    logic        forward_store;
    logic        forward_amo;
    req_op_e     amo_op;
    logic        amo_is_word;
    logic        amo_is_hi;
    data_t       amo_wdata;
    be_t         amo_be;
    logic [31:0] amo_rsp_word;
    logic        amo_pending_q;

    always_comb begin
      case (amo_op_i)
        CORE_AMO_SWAP: amo_op = AMO_SWAP;
        CORE_AMO_ADD:  amo_op = AMO_ADD;
        CORE_AMO_AND:  amo_op = AMO_AND;
        CORE_AMO_OR:   amo_op = AMO_OR;
        CORE_AMO_XOR:  amo_op = AMO_XOR;
        CORE_AMO_MAX:  amo_op = AMO_MAX;
        CORE_AMO_MAXU: amo_op = AMO_MAXU;
        CORE_AMO_MIN:  amo_op = AMO_MIN;
        CORE_AMO_MINU: amo_op = AMO_MINU;
        default:       amo_op = REQ_LOAD;
      endcase
    end

    // Word operand goes to both halves, the byte enables pick the lane
    assign amo_is_word = (amo_size_i == SIZE_WORD);
    assign amo_is_hi   = amo_addr_i[2];
    assign amo_wdata   = amo_is_word ? {2{amo_operand_i[31:0]}} : amo_operand_i;
    assign amo_be      = amo_is_word ? (amo_is_hi ? 8'hf0 : 8'h0f) : 8'hff;

    assign forward_store = core_req_i;
    assign forward_amo   = amo_req_i;

    // No new request while the AMO waits for its ack
    assign req_valid_o    = forward_store | (forward_amo & ~amo_pending_q);
    assign req_op_o       = forward_amo ? amo_op : REQ_STORE;
    assign req_addr_o     = forward_amo ? amo_addr_i : core_addr_i;
    assign req_wdata_o    = forward_amo ? amo_wdata : core_wdata_i;
    assign req_be_o       = forward_amo ? amo_be : core_be_i;
    assign req_size_o     = forward_amo ? amo_size_i : core_size_i;
    assign req_tid_o      = forward_amo ? AMO_TID : core_id_i;
    assign req_need_rsp_o = forward_amo;

    assign core_rvalid_o = rsp_valid_i & (rsp_tid_i != AMO_TID);
    assign core_rdata_o  = rsp_rdata_i;
    assign core_rid_o    = rsp_tid_i;

    // Operands are still held by the core during the ack cycle
    assign amo_rsp_word = amo_is_hi ? rsp_rdata_i[63:32] : rsp_rdata_i[31:0];
    assign amo_ack_o    = rsp_valid_i & (rsp_tid_i == AMO_TID);
    assign amo_result_o = amo_is_word ? {{32{amo_rsp_word[31]}}, amo_rsp_word}
                                      : rsp_rdata_i;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        amo_pending_q <= 1'b0;
      end else begin
        amo_pending_q <= (forward_amo & req_ready_i & ~amo_pending_q) |
                         (amo_pending_q & ~amo_ack_o);
      end
    end

    // Core keeps stores and AMOs apart
    forward_one_request: assert property (
      @(posedge clk_i) disable iff (rst_i) $onehot0({forward_store, forward_amo})
    ) else $error("store and AMO forwarded in the same cycle");
  end

endmodule

`default_nettype wire

// File: source/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array
  import l1d_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_i,

  input  wire logic    req_valid_i,
  input  wire req_op_e req_op_i,
  input  wire addr_t   req_addr_i,
  input  wire data_t   req_wdata_i,
  input  wire be_t     req_be_i,
  input  wire size_t   req_size_i,
  input  wire tid_t    req_tid_i,
  input  wire logic    req_need_rsp_i,
  input  wire sid_t    req_sid_i,

  output logic         rsp_valid_o,
  output sid_t         rsp_sid_o,
  output tid_t         rsp_tid_o,
  output data_t        rsp_rdata_o
);

  logic [WORD_IDX_WIDTH-1:0] idx;
  data_t                     mem [MEM_DEPTH];
  data_t                     old_data;
  data_t                     new_data;

  // Doubleword index, bits [10:3]
  assign idx      = req_addr_i[3 +: WORD_IDX_WIDTH];
  assign old_data = mem[idx];

  // Also merges plain store data under its byte enables
  amo_alu u_amo_alu (
    .op_i      (req_op_i),
    .size_i    (req_size_i),
    .be_i      (req_be_i),
    .old_i     (old_data),
    .operand_i (req_wdata_i),
    .new_o     (new_data)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (req_valid_i && (req_op_i != REQ_LOAD)) begin
      mem[idx] <= new_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i & req_need_rsp_i;
    end
  end

  // Loads and AMOs both return the value before the write
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_need_rsp_i) begin
      rsp_sid_o   <= req_sid_i;
      rsp_tid_o   <= req_tid_i;
      rsp_rdata_o <= old_data;
    end
  end

  store_without_rsp: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(req_valid_i && (req_op_i == REQ_STORE) && req_need_rsp_i)
  ) else $error("store request asks for a response");

endmodule

`default_nettype wire

// File: source/dcache_req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_req_arbiter
  import l1d_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_i,

  input  wire logic    ld_valid_i,
  input  wire req_op_e ld_op_i,
  input  wire addr_t   ld_addr_i,
  input  wire data_t   ld_wdata_i,
  input  wire be_t     ld_be_i,
  input  wire size_t   ld_size_i,
  input  wire tid_t    ld_tid_i,
  input  wire logic    ld_need_rsp_i,

  input  wire logic    st_valid_i,
  input  wire req_op_e st_op_i,
  input  wire addr_t   st_addr_i,
  input  wire data_t   st_wdata_i,
  input  wire be_t     st_be_i,
  input  wire size_t   st_size_i,
  input  wire tid_t    st_tid_i,
  input  wire logic    st_need_rsp_i,

  output logic         ld_ready_o,
  output logic         st_ready_o,

  output logic         mem_valid_o,
  output req_op_e      mem_op_o,
  output addr_t        mem_addr_o,
  output data_t        mem_wdata_o,
  output be_t          mem_be_o,
  output size_t        mem_size_o,
  output tid_t         mem_tid_o,
  output logic         mem_need_rsp_o,
  output sid_t         mem_sid_o,

  input  wire logic    mem_rsp_valid_i,
  input  wire sid_t    mem_rsp_sid_i,
  input  wire tid_t    mem_rsp_tid_i,
  input  wire data_t   mem_rsp_rdata_i,

  output logic         ld_rsp_valid_o,
  output logic         st_rsp_valid_o,
  output tid_t         rsp_tid_o,
  output data_t        rsp_rdata_o
);

  // High when the load port won the last grant
  logic ld_last_q;
  logic sel_st;

  assign sel_st = st_valid_i & (~ld_valid_i | ld_last_q);

  assign ld_ready_o  = ld_valid_i & ~sel_st;
  assign st_ready_o  = sel_st;
  assign mem_valid_o = ld_valid_i | st_valid_i;

  assign mem_op_o       = sel_st ? st_op_i : ld_op_i;
  assign mem_addr_o     = sel_st ? st_addr_i : ld_addr_i;
  assign mem_wdata_o    = sel_st ? st_wdata_i : ld_wdata_i;
  assign mem_be_o       = sel_st ? st_be_i : ld_be_i;
  assign mem_size_o     = sel_st ? st_size_i : ld_size_i;
  assign mem_tid_o      = sel_st ? st_tid_i : ld_tid_i;
  assign mem_need_rsp_o = sel_st ? st_need_rsp_i : ld_need_rsp_i;
  assign mem_sid_o      = sel_st ? SID_STORE : SID_LOAD;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ld_last_q <= 1'b0;
    end else if (mem_valid_o) begin
      ld_last_q <= ld_ready_o;
    end
  end

  // Response goes back to the port named by its sid
  assign ld_rsp_valid_o = mem_rsp_valid_i & (mem_rsp_sid_i == SID_LOAD);
  assign st_rsp_valid_o = mem_rsp_valid_i & (mem_rsp_sid_i == SID_STORE);
  assign rsp_tid_o      = mem_rsp_tid_i;
  assign rsp_rdata_o    = mem_rsp_rdata_i;

  // A waiting store is served right after the load port wins over it
  store_follows_load: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (ld_ready_o && st_valid_i) |=> (!st_valid_i || st_ready_o)
  ) else $error("store port not granted after losing to the load port");

endmodule

`default_nettype wire

// File: source/dcache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_subsystem
  import l1d_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_i,

  // Load port
  input  wire logic      ld_req_i,
  input  wire addr_t     ld_addr_i,
  input  wire be_t       ld_be_i,
  input  wire size_t     ld_size_i,
  input  wire tid_t      ld_id_i,
  output logic           ld_gnt_o,
  output logic           ld_rvalid_o,
  output data_t          ld_rdata_o,
  output tid_t           ld_rid_o,

  // Store port
  input  wire logic      st_req_i,
  input  wire addr_t     st_addr_i,
  input  wire data_t     st_wdata_i,
  input  wire be_t       st_be_i,
  input  wire size_t     st_size_i,
  output logic           st_gnt_o,

  // AMO port
  input  wire logic      amo_req_i,
  input  wire core_amo_e amo_op_i,
  input  wire addr_t     amo_addr_i,
  input  wire data_t     amo_operand_i,
  input  wire size_t     amo_size_i,
  output logic           amo_ack_o,
  output data_t          amo_result_o
);

  // Adapter requests
  logic    ld_valid, st_valid;
  req_op_e ld_op, st_op;
  addr_t   ld_addr, st_addr;
  data_t   ld_wdata, st_wdata;
  be_t     ld_be, st_be;
  size_t   ld_size, st_size;
  tid_t    ld_tid, st_tid;
  logic    ld_need_rsp, st_need_rsp;
  logic    ld_ready, st_ready;

  // Routed responses
  logic    ld_rsp_valid, st_rsp_valid;
  tid_t    rsp_tid;
  data_t   rsp_rdata;

  // Array side
  logic    mem_valid;
  req_op_e mem_op;
  addr_t   mem_addr;
  data_t   mem_wdata;
  be_t     mem_be;
  size_t   mem_size;
  tid_t    mem_tid;
  logic    mem_need_rsp;
  sid_t    mem_sid;
  logic    mem_rsp_valid;
  sid_t    mem_rsp_sid;
  tid_t    mem_rsp_tid;
  data_t   mem_rsp_rdata;

  core_dcache_adapter #(
    .is_load_port (1'b1)
  ) u_ld_adapter (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .core_req_i     (ld_req_i),
    .core_addr_i    (ld_addr_i),
    .core_wdata_i   ('0),
    .core_be_i      (ld_be_i),
    .core_size_i    (ld_size_i),
    .core_id_i      (ld_id_i),
    .core_gnt_o     (ld_gnt_o),
    .core_rvalid_o  (ld_rvalid_o),
    .core_rdata_o   (ld_rdata_o),
    .core_rid_o     (ld_rid_o),
    // No AMOs on the load port
    .amo_req_i      (1'b0),
    .amo_op_i       (CORE_AMO_NONE),
    .amo_addr_i     ('0),
    .amo_operand_i  ('0),
    .amo_size_i     ('0),
    .amo_ack_o      (),
    .amo_result_o   (),
    .req_valid_o    (ld_valid),
    .req_ready_i    (ld_ready),
    .req_op_o       (ld_op),
    .req_addr_o     (ld_addr),
    .req_wdata_o    (ld_wdata),
    .req_be_o       (ld_be),
    .req_size_o     (ld_size),
    .req_tid_o      (ld_tid),
    .req_need_rsp_o (ld_need_rsp),
    .rsp_valid_i    (ld_rsp_valid),
    .rsp_rdata_i    (rsp_rdata),
    .rsp_tid_i      (rsp_tid)
  );

  core_dcache_adapter #(
    .is_load_port (1'b0)
  ) u_st_adapter (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .core_req_i     (st_req_i),
    .core_addr_i    (st_addr_i),
    .core_wdata_i   (st_wdata_i),
    .core_be_i      (st_be_i),
    .core_size_i    (st_size_i),
    .core_id_i      ('0),
    .core_gnt_o     (st_gnt_o),
    .core_rvalid_o  (),
    .core_rdata_o   (),
    .core_rid_o     (),
    .amo_req_i      (amo_req_i),
    .amo_op_i       (amo_op_i),
    .amo_addr_i     (amo_addr_i),
    .amo_operand_i  (amo_operand_i),
    .amo_size_i     (amo_size_i),
    .amo_ack_o      (amo_ack_o),
    .amo_result_o   (amo_result_o),
    .req_valid_o    (st_valid),
    .req_ready_i    (st_ready),
    .req_op_o       (st_op),
    .req_addr_o     (st_addr),
    .req_wdata_o    (st_wdata),
    .req_be_o       (st_be),
    .req_size_o     (st_size),
    .req_tid_o      (st_tid),
    .req_need_rsp_o (st_need_rsp),
    .rsp_valid_i    (st_rsp_valid),
    .rsp_rdata_i    (rsp_rdata),
    .rsp_tid_i      (rsp_tid)
  );

  dcache_req_arbiter u_arbiter (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .ld_valid_i      (ld_valid),
    .ld_op_i         (ld_op),
    .ld_addr_i       (ld_addr),
    .ld_wdata_i      (ld_wdata),
    .ld_be_i         (ld_be),
    .ld_size_i       (ld_size),
    .ld_tid_i        (ld_tid),
    .ld_need_rsp_i   (ld_need_rsp),
    .st_valid_i      (st_valid),
    .st_op_i         (st_op),
    .st_addr_i       (st_addr),
    .st_wdata_i      (st_wdata),
    .st_be_i         (st_be),
    .st_size_i       (st_size),
    .st_tid_i        (st_tid),
    .st_need_rsp_i   (st_need_rsp),
    .ld_ready_o      (ld_ready),
    .st_ready_o      (st_ready),
    .mem_valid_o     (mem_valid),
    .mem_op_o        (mem_op),
    .mem_addr_o      (mem_addr),
    .mem_wdata_o     (mem_wdata),
    .mem_be_o        (mem_be),
    .mem_size_o      (mem_size),
    .mem_tid_o       (mem_tid),
    .mem_need_rsp_o  (mem_need_rsp),
    .mem_sid_o       (mem_sid),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_sid_i   (mem_rsp_sid),
    .mem_rsp_tid_i   (mem_rsp_tid),
    .mem_rsp_rdata_i (mem_rsp_rdata),
    .ld_rsp_valid_o  (ld_rsp_valid),
    .st_rsp_valid_o  (st_rsp_valid),
    .rsp_tid_o       (rsp_tid),
    .rsp_rdata_o     (rsp_rdata)
  );

  dcache_data_array u_data_array (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (mem_valid),
    .req_op_i       (mem_op),
    .req_addr_i     (mem_addr),
    .req_wdata_i    (mem_wdata),
    .req_be_i       (mem_be),
    .req_size_i     (mem_size),
    .req_tid_i      (mem_tid),
    .req_need_rsp_i (mem_need_rsp),
    .req_sid_i      (mem_sid),
    .rsp_valid_o    (mem_rsp_valid),
    .rsp_sid_o      (mem_rsp_sid),
    .rsp_tid_o      (mem_rsp_tid),
    .rsp_rdata_o    (mem_rsp_rdata)
  );

endmodule

`default_nettype wire

// File: source/l1d_pkg.sv
`default_nettype none

package l1d_pkg;

  // Bus widths
  localparam int ADDR_WIDTH     = 32;
  localparam int WORD_IDX_WIDTH = 8;
  localparam int DATA_WIDTH     = 64;
  localparam int BE_WIDTH       = 8;
  localparam int TID_WIDTH      = 4;
  localparam int MEM_DEPTH      = 1 << WORD_IDX_WIDTH;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;
  typedef logic [1:0]            size_t;
  typedef logic [TID_WIDTH-1:0]  tid_t;
  typedef logic                  sid_t;

  // Access size code for a 32-bit word
  localparam size_t SIZE_WORD = 2'd2;

  // All-ones id marks an AMO response
  localparam tid_t AMO_TID = '1;

  localparam sid_t SID_LOAD  = 1'b0;
  localparam sid_t SID_STORE = 1'b1;

  // Operation as seen by the cache
  typedef enum logic [3:0] {
    REQ_LOAD,
    REQ_STORE,
    AMO_SWAP,
    AMO_ADD,
    AMO_AND,
    AMO_OR,
    AMO_XOR,
    AMO_MAX,
    AMO_MAXU,
    AMO_MIN,
    AMO_MINU
  } req_op_e;

  // Operation code driven by the core
  typedef enum logic [3:0] {
    CORE_AMO_NONE = 4'h0,
    CORE_AMO_SWAP = 4'h3,
    CORE_AMO_ADD  = 4'h4,
    CORE_AMO_AND  = 4'h5,
    CORE_AMO_OR   = 4'h6,
    CORE_AMO_XOR  = 4'h7,
    CORE_AMO_MAX  = 4'h8,
    CORE_AMO_MAXU = 4'h9,
    CORE_AMO_MIN  = 4'ha,
    CORE_AMO_MINU = 4'hb
  } core_amo_e;

endpackage

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held over five rising edges, released mid-cycle
  initial begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/tb_dcache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_subsystem
  import l1d_pkg::*;
();

  localparam int NUM_OPS         = 120;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 20 + 100;
  localparam int GRANT_LIMIT     = 20;

  logic        clk_i;
  logic        rst_i;
  logic        ld_req_i;
  addr_t       ld_addr_i;
  be_t         ld_be_i;
  size_t       ld_size_i;
  tid_t        ld_id_i;
  logic        ld_gnt_o;
  logic        ld_rvalid_o;
  data_t       ld_rdata_o;
  tid_t        ld_rid_o;
  logic        st_req_i;
  addr_t       st_addr_i;
  data_t       st_wdata_i;
  be_t         st_be_i;
  size_t       st_size_i;
  logic        st_gnt_o;
  logic        amo_req_i;
  core_amo_e   amo_op_i;
  addr_t       amo_addr_i;
  data_t       amo_operand_i;
  size_t       amo_size_i;
  logic        amo_ack_o;
  data_t       amo_result_o;

  // Expected memory contents
  logic [63:0] shadow [256];
  logic [31:0] rng_state;
  int          error_count;
  int          check_count;

  tb_clock_gen u_clock_gen (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  dcache_subsystem DUT (.*);

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic core_amo_e amo_op_at(input int i);
    case (i)
      0:       return CORE_AMO_SWAP;
      1:       return CORE_AMO_ADD;
      2:       return CORE_AMO_AND;
      3:       return CORE_AMO_OR;
      4:       return CORE_AMO_XOR;
      5:       return CORE_AMO_MAX;
      6:       return CORE_AMO_MAXU;
      7:       return CORE_AMO_MIN;
      default: return CORE_AMO_MINU;
    endcase
  endfunction

  // New memory value, only the low 32 bits count for a word
  function automatic logic [63:0] amo_apply(input core_amo_e op, input logic [63:0] old,
                                            input logic [63:0] opd, input bit is_word);
    logic [63:0]        old_u;
    logic [63:0]        opd_u;
    logic signed [64:0] old_s;
    logic signed [64:0] opd_s;
    logic [63:0]        res;
    old_u = is_word ? {32'd0, old[31:0]} : old;
    opd_u = is_word ? {32'd0, opd[31:0]} : opd;
    old_s = is_word ? $signed(old[31:0]) : $signed(old);
    opd_s = is_word ? $signed(opd[31:0]) : $signed(opd);
    case (op)
      CORE_AMO_SWAP: res = opd_u;
      CORE_AMO_ADD:  res = old_u + opd_u;
      CORE_AMO_AND:  res = old_u & opd_u;
      CORE_AMO_OR:   res = old_u | opd_u;
      CORE_AMO_XOR:  res = old_u ^ opd_u;
      CORE_AMO_MAX:  res = (old_s > opd_s) ? old_u : opd_u;
      CORE_AMO_MAXU: res = (old_u > opd_u) ? old_u : opd_u;
      CORE_AMO_MIN:  res = (old_s < opd_s) ? old_u : opd_u;
      CORE_AMO_MINU: res = (old_u < opd_u) ? old_u : opd_u;
      default:       res = old_u;
    endcase
    return res;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  // Grant is combinational, so it is sampled just after the falling edge
  task automatic wait_grant(input bit load_port, input string what);
    int waited;
    waited = 0;
    #1;
    while ((load_port ? ld_gnt_o : st_gnt_o) !== 1'b1 && waited < GRANT_LIMIT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if ((load_port ? ld_gnt_o : st_gnt_o) !== 1'b1) begin
      $display("%s request was not granted within %0d cycles", what, GRANT_LIMIT);
      error_count++;
    end
  endtask

  task automatic do_load(input logic [31:0] addr);
    tid_t id;
    id = tid_t'(next_random() % AMO_TID);
    @(negedge clk_i);
    ld_req_i  = 1'b1;
    ld_addr_i = addr;
    ld_be_i   = 8'hff;
    ld_size_i = 2'd3;
    ld_id_i   = id;
    wait_grant(1'b1, "load");
    check_value("ld_rvalid_o", ld_rvalid_o, 1'b0);
    @(negedge clk_i);
    check_value("ld_rvalid_o", ld_rvalid_o, 1'b1);
    check_value("ld_rdata_o", ld_rdata_o, shadow[addr[10:3]]);
    check_value("ld_rid_o", ld_rid_o, id);
    ld_req_i = 1'b0;
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] be);
    @(negedge clk_i);
    st_req_i   = 1'b1;
    st_addr_i  = addr;
    st_wdata_i = data;
    st_be_i    = be;
    st_size_i  = 2'd3;
    wait_grant(1'b0, "store");
    @(negedge clk_i);
    st_req_i = 1'b0;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        shadow[addr[10:3]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic do_amo(input core_amo_e op, input logic [31:0] addr,
                        input logic [63:0] operand, input logic [1:0] size);
    logic [7:0]  idx;
    logic [63:0] old_dw;
    logic [31:0] old_w;
    logic [63:0] new_val;
    logic [63:0] expect_result;
    idx    = addr[10:3];
    old_dw = shadow[idx];
    old_w  = addr[2] ? old_dw[63:32] : old_dw[31:0];
    if (size == 2'd2) begin
      new_val       = amo_apply(op, {32'd0, old_w}, operand, 1'b1);
      expect_result = {{32{old_w[31]}}, old_w};
      if (addr[2]) begin
        shadow[idx][63:32] = new_val[31:0];
      end else begin
        shadow[idx][31:0] = new_val[31:0];
      end
    end else begin
      expect_result = old_dw;
      shadow[idx]   = amo_apply(op, old_dw, operand, 1'b0);
    end
    @(negedge clk_i);
    amo_req_i     = 1'b1;
    amo_op_i      = op;
    amo_addr_i    = addr;
    amo_operand_i = operand;
    amo_size_i    = size;
    wait_grant(1'b0, "AMO");
    check_value("amo_ack_o", amo_ack_o, 1'b0);
    @(negedge clk_i);
    check_value("amo_ack_o", amo_ack_o, 1'b1);
    check_value("amo_result_o", amo_result_o, expect_result);
    // Pending AMO must not be granted again
    check_value("st_gnt_o", st_gnt_o, 1'b0);
    amo_req_i = 1'b0;
    @(negedge clk_i);
    check_value("amo_ack_o", amo_ack_o, 1'b0);
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check_value("ld_rvalid_o", ld_rvalid_o, 1'b0);
    check_value("amo_ack_o", amo_ack_o, 1'b0);
    check_value("ld_gnt_o", ld_gnt_o, 1'b0);
  endtask

  // Load wins first after reset, the held store follows
  task automatic test_contention();
    logic [31:0] ld_addr;
    logic [31:0] st_addr;
    logic [63:0] st_data;
    ld_addr = next_random() & 32'hffff_fff8;
    st_addr = ld_addr ^ 32'h8;
    st_data = {next_random(), next_random()};
    @(negedge clk_i);
    ld_req_i   = 1'b1;
    ld_addr_i  = ld_addr;
    ld_be_i    = 8'hff;
    ld_size_i  = 2'd3;
    ld_id_i    = 4'h3;
    st_req_i   = 1'b1;
    st_addr_i  = st_addr;
    st_wdata_i = st_data;
    st_be_i    = 8'hff;
    st_size_i  = 2'd3;
    #1;
    check_value("ld_gnt_o", ld_gnt_o, 1'b1);
    check_value("st_gnt_o", st_gnt_o, 1'b0);
    @(negedge clk_i);
    check_value("ld_rvalid_o", ld_rvalid_o, 1'b1);
    check_value("ld_rdata_o", ld_rdata_o, shadow[ld_addr[10:3]]);
    check_value("ld_rid_o", ld_rid_o, 4'h3);
    ld_req_i = 1'b0;
    #1;
    check_value("st_gnt_o", st_gnt_o, 1'b1);
    @(negedge clk_i);
    st_req_i = 1'b0;
    shadow[st_addr[10:3]] = st_data;
    do_load(st_addr);
  endtask

  task automatic test_store_load();
    logic [31:0] addr;
    logic [31:0] r;
    repeat (16) begin
      addr = next_random() & 32'hffff_fff8;
      r    = next_random();
      do_store(addr, {next_random(), next_random()}, r[7:0]);
      do_load(addr);
    end
  endtask

  task automatic test_amo(input bit is_word);
    logic [31:0] addr;
    for (int i = 0; i < 9; i++) begin
      for (int hi = 0; hi < (is_word ? 2 : 1); hi++) begin
        addr = (next_random() & 32'hffff_fff8) | (hi << 2);
        do_store(addr, {next_random(), next_random()}, 8'hff);
        do_amo(amo_op_at(i), addr, {next_random(), next_random()},
               is_word ? 2'd2 : 2'd3);
        do_load(addr);
      end
    end
  endtask

  initial begin
    ld_req_i      = 1'b0;
    ld_addr_i     = '0;
    ld_be_i       = '0;
    ld_size_i     = '0;
    ld_id_i       = '0;
    st_req_i      = 1'b0;
    st_addr_i     = '0;
    st_wdata_i    = '0;
    st_be_i       = '0;
    st_size_i     = '0;
    amo_req_i     = 1'b0;
    amo_op_i      = CORE_AMO_NONE;
    amo_addr_i    = '0;
    amo_operand_i = '0;
    amo_size_i    = '0;
    error_count   = 0;
    check_count   = 0;
    rng_state     = 32'hb9ad8890;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = '0;
    end
    wait (rst_i === 1'b1);
    wait (rst_i === 1'b0);

    test_reset_state();
    test_contention();
    repeat (4) begin
      do_load(next_random() & 32'hffff_fff8);
    end
    test_store_load();
    test_amo(1'b0);
    test_amo(1'b1);

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
